// File: build.f
+incdir+hw
hw/issue_pkg.sv
hw/int_regfile.sv
hw/operand_hazard_check.sv
hw/operand_select.sv
hw/issue_register.sv
hw/issue_read_operands.sv
testbench/tb_issue_read_operands.sv

// File: Makefile
# Verilator build and run of the issue stage testbench

TOP := tb_issue_read_operands

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: testbench/tb_issue_read_operands.sv
/*
  Testbench of the integer issue and operand-read stage. Fills the
  register file through the commit ports, then runs a table of scoreboard
  entries with their hazard, ready and commit settings and checks ack,
  lookup addresses, unit valid and the registered operands of each row.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issue_config.svh"

module tb_issue_read_operands
    import issue_pkg::*;
();

    // ack is polled in 1 ns steps inside the low half of the clock
    localparam int ACK_POLL_NS = 10;
    localparam unit_valid_t V_NONE = 5'b00000;
    localparam unit_valid_t V_ALU  = 5'b10000;
    localparam unit_valid_t V_BR   = 5'b01000;
    localparam unit_valid_t V_LSU  = 5'b00100;
    localparam unit_valid_t V_MUL  = 5'b00010;
    localparam unit_valid_t V_CSR  = 5'b00001;

    // one table row with inputs first and expected values after
    typedef struct packed {
        issue_entry_t                        entry;
        clobber_t                            clobber;
        fwd_t                                fwd;
        unit_ready_t                         ready;
        commit_port_t [`NR_COMMIT_PORTS-1:0] commit;
        logic                                flush;
        logic                                exp_ack;
        unit_valid_t                         exp_valid;
        logic [`XLEN-1:0]                    exp_a;
        logic [`XLEN-1:0]                    exp_b;
    } row_t;

    logic                                clk_i;
    logic                                rst_ni;
    logic                                flush_i;
    issue_entry_t                        issue_entry_i;
    logic                                issue_valid_i;
    logic                                issue_ack_o;
    logic [`REG_ADDR_BITS-1:0]           rs1_o;
    logic [`REG_ADDR_BITS-1:0]           rs2_o;
    fwd_t                                fwd_i;
    clobber_t                            clobber_i;
    commit_port_t [`NR_COMMIT_PORTS-1:0] commit_i;
    unit_ready_t                         unit_ready_i;
    fu_data_t                            fu_data_o;
    unit_valid_t                         unit_valid_o;

    // register contents as the commit writes left them
    logic [`XLEN-1:0] model [`NR_REGS];
    logic [31:0]      lcg_state;
    int               tag_seq;
    int               error_count;
    int               tests_failed;
    row_t             nr;
    row_t             rows [$];
    string            names [$];

    issue_read_operands u_issue_read_operands (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .issue_entry_i (issue_entry_i),
        .issue_valid_i (issue_valid_i),
        .issue_ack_o   (issue_ack_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .fwd_i         (fwd_i),
        .clobber_i     (clobber_i),
        .commit_i      (commit_i),
        .unit_ready_i  (unit_ready_i),
        .fu_data_o     (fu_data_o),
        .unit_valid_o  (unit_valid_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // fresh entry with pc and tag from the row count and a random immediate
    function automatic issue_entry_t make_entry(input fu_t fu, input fu_op_t op,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd);
        issue_entry_t e;
        e = '0;
        e.pc = 32'h0000_1000 + (32'(tag_seq) << 2);
        e.trans_id = tag_seq[`TRANS_ID_BITS-1:0];
        e.fu = fu;
        e.op = op;
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.rd = rd;
        e.result = lcg_next();
        tag_seq++;
        return e;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail time=%0t signal=issue_ack_o expected=%b got=%b", $time, exp, got);
            error_count++;
        end
    endtask

    task automatic check_reg_addr(input string name, input logic [`REG_ADDR_BITS-1:0] got,
            input logic [`REG_ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            $display("Fail time=%0t signal=%s expected=%0d got=%0d", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic check_unit_valid(input unit_valid_t got, input unit_valid_t exp);
        if (got !== exp) begin
            $display("Fail time=%0t signal=unit_valid_o expected=%b got=%b", $time, exp, got);
            error_count++;
        end
    endtask

    task automatic check_fu_data(input fu_data_t got, input fu_data_t exp);
        if (got !== exp) begin
            $display("Fail time=%0t signal=fu_data_o expected=%h got=%h", $time, exp, got);
            error_count++;
        end
    endtask

    // ----------------------------------------
    // table building
    // ----------------------------------------
    task automatic clear_row();
        nr = '0;
        nr.ready = '1;
    endtask

    task automatic add_row(input string name, input logic ack, input unit_valid_t v,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        nr.exp_ack = ack;
        nr.exp_valid = v;
        nr.exp_a = a;
        nr.exp_b = b;
        rows.push_back(nr);
        names.push_back(name);
        // later rows see the commits of this row and x0 stays zero
        for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
            if (nr.commit[p].we && (nr.commit[p].waddr != '0)) begin
                model[nr.commit[p].waddr] = nr.commit[p].wdata;
            end
        end
        clear_row();
    endtask

    task automatic fill_registers();
        for (int unsigned r = 1; r < `NR_REGS; r += 2) begin
            commit_i = '0;
            commit_i[0].we = 1'b1;
            commit_i[0].waddr = 5'(r);
            commit_i[0].wdata = lcg_next();
            model[r] = commit_i[0].wdata;
            commit_i[1].we = 1'b1;
            if (r + 1 < `NR_REGS) begin
                commit_i[1].waddr = 5'(r + 1);
                commit_i[1].wdata = lcg_next();
                model[r + 1] = commit_i[1].wdata;
            end else begin
                // write to x0 that has to be dropped
                commit_i[1].waddr = '0;
                commit_i[1].wdata = 32'hffff_ffff;
            end
            @(negedge clk_i);
        end
        commit_i = '0;
    endtask

    task automatic build_table();
        logic [`XLEN-1:0] d;
        clear_row();
        // register read
        nr.entry = make_entry(ALU, ADD, 5'd3, 5'd7, 5'd10);
        add_row("alu reads rs1 and rs2", 1'b1, V_ALU, model[3], model[7]);
        nr.entry = make_entry(ALU, OR_OP, 5'd0, 5'd5, 5'd11);
        add_row("x0 reads zero", 1'b1, V_ALU, '0, model[5]);
        // forwarding where csr results only reach sfence
        d = lcg_next();
        nr.entry = make_entry(ALU, SUB, 5'd4, 5'd6, 5'd13);
        nr.clobber[4] = ALU;
        nr.fwd.rs1_valid = 1'b1;
        nr.fwd.rs1_data = d;
        add_row("alu result forwarded to rs1", 1'b1, V_ALU, d, model[6]);
        nr.entry = make_entry(ALU, ADD, 5'd4, 5'd6, 5'd13);
        nr.clobber[4] = CSR;
        nr.fwd.rs1_valid = 1'b1;
        nr.fwd.rs1_data = d;
        add_row("csr result in flight stalls", 1'b0, V_NONE, model[4], model[6]);
        nr.entry = make_entry(CSR, SFENCE_VMA, 5'd4, 5'd6, 5'd0);
        nr.clobber[4] = CSR;
        nr.fwd.rs1_valid = 1'b1;
        nr.fwd.rs1_data = d;
        add_row("sfence takes the csr result", 1'b1, V_CSR, d, model[6]);
        nr.entry = make_entry(ALU, XOR_OP, 5'd8, 5'd9, 5'd14);
        nr.clobber[9] = LOAD;
        add_row("forward not yet valid stalls", 1'b0, V_NONE, model[8], model[9]);
        // operand substitution
        nr.entry = make_entry(ALU, ADD, 5'd1, 5'd2, 5'd15);
        nr.entry.use_pc = 1'b1;
        add_row("use_pc selects the pc", 1'b1, V_ALU, nr.entry.pc, model[2]);
        nr.entry = make_entry(CSR, CSR_RW, 5'd17, 5'd2, 5'd16);
        nr.entry.use_zimm = 1'b1;
        nr.clobber[17] = ALU;
        add_row("use_zimm selects the rs1 field", 1'b1, V_CSR, 32'd17, model[2]);
        nr.entry = make_entry(ALU, ADD, 5'd18, 5'd19, 5'd21);
        nr.entry.use_imm = 1'b1;
        add_row("use_imm selects the immediate", 1'b1, V_ALU, model[18], nr.entry.result);
        nr.entry = make_entry(STORE, SW, 5'd22, 5'd23, 5'd0);
        nr.entry.use_imm = 1'b1;
        add_row("store keeps rs2 in operand b", 1'b1, V_LSU, model[22], model[23]);
        nr.entry = make_entry(CTRL_FLOW, BEQ, 5'd24, 5'd25, 5'd0);
        nr.entry.use_imm = 1'b1;
        add_row("branch keeps rs2 in operand b", 1'b1, V_BR, model[24], model[25]);
        // WAW on rd
        nr.entry = make_entry(ALU, AND_OP, 5'd1, 5'd2, 5'd12);
        nr.clobber[12] = MULT;
        add_row("clobbered rd blocks issue", 1'b0, V_NONE, model[1], model[2]);
        nr.entry = make_entry(ALU, AND_OP, 5'd1, 5'd2, 5'd12);
        nr.clobber[12] = MULT;
        nr.commit[1].we = 1'b1;
        nr.commit[1].waddr = 5'd12;
        nr.commit[1].wdata = lcg_next();
        add_row("rd retired by commit this cycle", 1'b1, V_ALU, model[1], model[2]);
        // unit select and back-pressure
        nr.entry = make_entry(LOAD, LW, 5'd26, 5'd0, 5'd27);
        nr.entry.use_imm = 1'b1;
        nr.ready.lsu = 1'b0;
        add_row("lsu not ready holds a load", 1'b0, V_NONE, model[26], nr.entry.result);
        nr.entry = make_entry(LOAD, LW, 5'd26, 5'd0, 5'd27);
        nr.entry.use_imm = 1'b1;
        add_row("load goes to the lsu", 1'b1, V_LSU, model[26], nr.entry.result);
        nr.entry = make_entry(ALU, SLL, 5'd28, 5'd29, 5'd30);
        nr.ready.flu = 1'b0;
        add_row("busy fixed-latency unit holds alu", 1'b0, V_NONE, model[28], model[29]);
        nr.entry = make_entry(CTRL_FLOW, JALR, 5'd5, 5'd0, 5'd1);
        nr.ready.lsu = 1'b0;
        add_row("branch ignores a busy lsu", 1'b1, V_BR, model[5], '0);
        // multiply ordering
        nr.entry = make_entry(MULT, MUL, 5'd3, 5'd4, 5'd31);
        add_row("multiply issued", 1'b1, V_MUL, model[3], model[4]);
        nr.entry = make_entry(MULT, MUL, 5'd5, 5'd6, 5'd20);
        add_row("multiply after multiply", 1'b1, V_MUL, model[5], model[6]);
        nr.entry = make_entry(ALU, ADD, 5'd7, 5'd8, 5'd21);
        add_row("alu held after multiply", 1'b0, V_NONE, model[7], model[8]);
        // pass-through and flush
        nr.entry = make_entry(ALU, ADD, 5'd9, 5'd10, 5'd11);
        nr.entry.ex_valid = 1'b1;
        nr.clobber[9] = LOAD;
        add_row("exception entry passes", 1'b1, V_NONE, model[9], model[10]);
        nr.entry = make_entry(NONE, ADD, 5'd11, 5'd13, 5'd14);
        nr.ready = '0;
        add_row("entry without a unit passes", 1'b1, V_NONE, model[11], model[13]);
        nr.entry = make_entry(ALU, ADD, 5'd15, 5'd16, 5'd17);
        nr.flush = 1'b1;
        add_row("flush drops the alu valid", 1'b1, V_NONE, model[15], model[16]);
    endtask

    // ----------------------------------------
    // row execution
    // ----------------------------------------
    // entered and left on a falling edge
    task automatic run_row(input int i);
        row_t     r;
        fu_data_t exp_data;
        logic     got_ack;
        int       n;
        int       errs_before;
        r = rows[i];
        errs_before = error_count;
        issue_entry_i = r.entry;
        issue_valid_i = 1'b1;
        fwd_i = r.fwd;
        clobber_i = r.clobber;
        unit_ready_i = r.ready;
        commit_i = r.commit;
        flush_i = r.flush;
        got_ack = 1'b0;
        n = 0;
        while (!got_ack && (n < ACK_POLL_NS)) begin
            #1;
            n++;
            got_ack = (issue_ack_o === 1'b1);
        end
        check_ack(got_ack, r.exp_ack);
        // scoreboard lookup follows the entry's source fields
        check_reg_addr("rs1_o", rs1_o, r.entry.rs1);
        check_reg_addr("rs2_o", rs2_o, r.entry.rs2);
        @(posedge clk_i);
        @(negedge clk_i);
        check_unit_valid(unit_valid_o, r.exp_valid);
        // payload only matters for an acked entry
        if (r.exp_ack) begin
            exp_data.fu = r.entry.fu;
            exp_data.op = r.entry.op;
            exp_data.operand_a = r.exp_a;
            exp_data.operand_b = r.exp_b;
            exp_data.imm = r.entry.result;
            exp_data.trans_id = r.entry.trans_id;
            check_fu_data(fu_data_o, exp_data);
        end
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", i, names[i]);
        end else begin
            $display("test %0d %s: mismatch", i, names[i]);
            tests_failed++;
        end
    endtask

    initial begin
        fu_data_t reset_data;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        issue_entry_i = '0;
        issue_valid_i = 1'b0;
        fwd_i = '0;
        clobber_i = '0;
        commit_i = '0;
        unit_ready_i = '1;
        lcg_state = 32'hc68c58b7;
        tag_seq = 0;
        error_count = 0;
        tests_failed = 0;
        for (int r = 0; r < `NR_REGS; r++) begin
            model[r] = '0;
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // valids low and payload cleared out of reset
        check_unit_valid(unit_valid_o, V_NONE);
        reset_data = '0;
        reset_data.fu = NONE;
        reset_data.op = ADD;
        check_fu_data(fu_data_o, reset_data);
        fill_registers();
        build_table();
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        issue_valid_i = 1'b0;
        commit_i = '0;
        flush_i = 1'b0;
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 rows.size(), tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/issue_read_operands.sv
/*
  Integer issue and operand-read stage. Takes one scoreboard entry per
  cycle, acks it once its sources and unit are available, reads the
  register file or forwarded data, and presents the operands with one unit
  valid to the execute units in the next cycle.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issue_config.svh"

module issue_read_operands
    import issue_pkg::*;
(
    input  wire logic                              clk_i,
    input  wire logic                              rst_ni,
    input  wire logic                              flush_i,
    // scoreboard entry handshake
    input  issue_entry_t                           issue_entry_i,
    input  wire logic                              issue_valid_i,
    output logic                                   issue_ack_o,
    // forwarding lookup, answered in the same cycle
    output logic      [`REG_ADDR_BITS-1:0]         rs1_o,
    output logic      [`REG_ADDR_BITS-1:0]         rs2_o,
    input  fwd_t                                   fwd_i,
    input  clobber_t                               clobber_i,
    // commit writes
    input  commit_port_t [`NR_COMMIT_PORTS-1:0]    commit_i,
    // execute units
    input  unit_ready_t                            unit_ready_i,
    output fu_data_t                               fu_data_o,
    output unit_valid_t                            unit_valid_o
);

    logic [`XLEN-1:0] rdata_a;
    logic [`XLEN-1:0] rdata_b;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] imm;
    logic             fwd_rs1;
    logic             fwd_rs2;
    logic             mult_pending;

    // scoreboard lookup addresses
    assign rs1_o = issue_entry_i.rs1;
    assign rs2_o = issue_entry_i.rs2;

    int_regfile #(
        .NR_WRITE_PORTS (`NR_COMMIT_PORTS)
    ) u_int_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_entry_i.rs1),
        .raddr_b_i (issue_entry_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    // issue decision
    operand_hazard_check u_operand_hazard_check (
        .issue_entry_i  (issue_entry_i),
        .issue_valid_i  (issue_valid_i),
        .fwd_i          (fwd_i),
        .clobber_i      (clobber_i),
        .commit_i       (commit_i),
        .unit_ready_i   (unit_ready_i),
        .mult_pending_i (mult_pending),
        .fwd_rs1_o      (fwd_rs1),
        .fwd_rs2_o      (fwd_rs2),
        .issue_ack_o    (issue_ack_o)
    );

    // operand build
    operand_select u_operand_select (
        .issue_entry_i (issue_entry_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .fwd_i         (fwd_i),
        .fwd_rs1_i     (fwd_rs1),
        .fwd_rs2_i     (fwd_rs2),
        .operand_a_o   (operand_a),
        .operand_b_o   (operand_b),
        .imm_o         (imm)
    );

    // ID/EX register
    issue_register u_issue_register (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_entry_i  (issue_entry_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ack_i    (issue_ack_o),
        .operand_a_i    (operand_a),
        .operand_b_i    (operand_b),
        .imm_i          (imm),
        .fu_data_o      (fu_data_o),
        .unit_valid_o   (unit_valid_o),
        .mult_pending_o (mult_pending)
    );

endmodule

`default_nettype wire

// File: hw/issue_register.sv
/*
  ID/EX register of the issue stage. Samples operands and entry fields
  every clock and raises the valid of the target unit one cycle after an
  accepted entry without exception. Flush drops all valids. The registered
  multiply valid is fed back to the hazard check.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issue_config.svh"

module issue_register
    import issue_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire logic             flush_i,
    input  issue_entry_t          issue_entry_i,
    input  wire logic             issue_valid_i,
    input  wire logic             issue_ack_i,
    input  wire logic [`XLEN-1:0] operand_a_i,
    input  wire logic [`XLEN-1:0] operand_b_i,
    input  wire logic [`XLEN-1:0] imm_i,
    output fu_data_t              fu_data_o,
    output unit_valid_t           unit_valid_o,
    output logic                  mult_pending_o
);

    logic accept;

    // exception entries are acked but never reach a unit
    assign accept = issue_valid_i && issue_ack_i && !issue_entry_i.ex_valid;

    // ----------------------------------------
    // payload
    // ----------------------------------------
    // sampled every cycle, only meaningful together with a valid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{fu: NONE, op: ADD, default: '0};
        end else begin
            fu_data_o.fu        <= issue_entry_i.fu;
            fu_data_o.op        <= issue_entry_i.op;
            fu_data_o.operand_a <= operand_a_i;
            fu_data_o.operand_b <= operand_b_i;
            fu_data_o.imm       <= imm_i;
            fu_data_o.trans_id  <= issue_entry_i.trans_id;
        end
    end

    // ----------------------------------------
    // unit valids
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            unit_valid_o <= '0;
        end else begin
            // single-cycle pulses
            unit_valid_o <= '0;
            if (accept && !flush_i) begin
                unique case (issue_entry_i.fu)
                    ALU:         unit_valid_o.alu    <= 1'b1;
                    CTRL_FLOW:   unit_valid_o.branch <= 1'b1;
                    LOAD, STORE: unit_valid_o.lsu    <= 1'b1;
                    MULT:        unit_valid_o.mult   <= 1'b1;
                    CSR:         unit_valid_o.csr    <= 1'b1;
                    default:     unit_valid_o        <= '0;
                endcase
            end
        end
    end

    assign mult_pending_o = unit_valid_o.mult;

    // one entry per cycle, so at most one unit starts
    valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(unit_valid_o));

    // branch unit resolves from both operands right away
    branch_operands_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        unit_valid_o.branch |-> !$isunknown({fu_data_o.operand_a, fu_data_o.operand_b}));

endmodule

`default_nettype wire

// File: hw/operand_select.sv
/*
  Operand multiplexer of the issue stage. Builds operand A and B from the
  register file, forwarded scoreboard data, the PC, the zimm field or the
  immediate, following the flags of the entry. Combinational.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issue_config.svh"

module operand_select
    import issue_pkg::*;
(
    input  issue_entry_t          issue_entry_i,
    // register file read data
    input  wire logic [`XLEN-1:0] rdata_a_i,
    input  wire logic [`XLEN-1:0] rdata_b_i,
    // in-flight values and the hazard check's choice
    input  fwd_t                  fwd_i,
    input  wire logic             fwd_rs1_i,
    input  wire logic             fwd_rs2_i,
    output logic      [`XLEN-1:0] operand_a_o,
    output logic      [`XLEN-1:0] operand_b_o,
    output logic      [`XLEN-1:0] imm_o
);

    // immediate always travels, stores and branches need it next to two regs
    assign imm_o = issue_entry_i.result;

    always_comb begin : operand_mux
        // register file by default, forwarded value if still in flight
        operand_a_o = fwd_rs1_i ? fwd_i.rs1_data : rdata_a_i;
        operand_b_o = fwd_rs2_i ? fwd_i.rs2_data : rdata_b_i;

        // auipc / jal style, full pc
        if (issue_entry_i.use_pc) begin
            operand_a_o = issue_entry_i.pc;
        end
        // csr immediate forms, zero extended rs1 field
        if (issue_entry_i.use_zimm) begin
            operand_a_o = {{(`XLEN-`REG_ADDR_BITS){1'b0}}, issue_entry_i.rs1};
        end
        // store and ctrl flow keep rs2 in operand b
        if (issue_entry_i.use_imm
            && (issue_entry_i.fu != STORE)
            && (issue_entry_i.fu != CTRL_FLOW)) begin
            operand_b_o = issue_entry_i.result;
        end
    end

endmodule

`default_nettype wire

// File: hw/operand_hazard_check.sv
/*
  Issue decision for the entry at the head of the scoreboard. Looks up the
  clobber list for RAW and WAW hazards, picks which sources are forwarded,
  checks the needed unit is ready and the multiply ordering rule, and
  produces issue_ack in the same cycle. Purely combinational.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issue_config.svh"

module operand_hazard_check
    import issue_pkg::*;
(
    input  issue_entry_t                           issue_entry_i,
    input  wire logic                              issue_valid_i,
    input  fwd_t                                   fwd_i,
    input  clobber_t                               clobber_i,
    input  commit_port_t [`NR_COMMIT_PORTS-1:0]    commit_i,
    input  unit_ready_t                            unit_ready_i,
    // a multiply went out last cycle
    input  wire logic                              mult_pending_i,
    output logic                                   fwd_rs1_o,
    output logic                                   fwd_rs2_o,
    output logic                                   issue_ack_o
);

    // pending writers of the entry's registers
    fu_t  rs1_writer;
    fu_t  rs2_writer;
    fu_t  rd_writer;
    logic stall;
    logic fu_busy;
    logic rd_free;

    assign rs1_writer = clobber_i[issue_entry_i.rs1];
    assign rs2_writer = clobber_i[issue_entry_i.rs2];
    assign rd_writer  = clobber_i[issue_entry_i.rd];

    // ----------------------------------------
    // unit busy
    // ----------------------------------------
    always_comb begin : unit_busy
        unique case (issue_entry_i.fu)
            NONE:                      fu_busy = 1'b0;
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = !unit_ready_i.flu;
            LOAD, STORE:               fu_busy = !unit_ready_i.lsu;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------
    // RAW check and forwarding
    // ----------------------------------------
    // csr results in flight are not forwardable, only sfence may take them
    always_comb begin : operands_available
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        stall     = 1'b0;
        // zimm puts an immediate in the rs1 field, nothing to wait on
        if (!issue_entry_i.use_zimm && (rs1_writer != NONE)) begin
            if (fwd_i.rs1_valid && ((rs1_writer != CSR) || (issue_entry_i.op == SFENCE_VMA))) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_writer != NONE) begin
            if (fwd_i.rs2_valid && ((rs2_writer != CSR) || (issue_entry_i.op == SFENCE_VMA))) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // WAW check
    // ----------------------------------------
    // rd is free when nobody writes it or commit retires that write now
    always_comb begin : waw_check
        rd_free = (rd_writer == NONE);
        for (int unsigned p = 0; p < `NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_entry_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less entries just pass through
            if (issue_entry_i.ex_valid || (issue_entry_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the fixed-latency result bus is shared, only a multiply may follow a multiply
        if (mult_pending_i && (issue_entry_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // scoreboard only pops on a handshake with a valid entry
    always_comb begin : ack_check
        ack_needs_valid: assert final (!issue_ack_o || issue_valid_i);
    end

endmodule

`default_nettype wire

// File: hw/int_regfile.sv
/*
  Integer register file: 32 entries, two combinational read ports and a
  configurable number of commit write ports. Writes land at the clock edge
  and are readable in the next cycle. x0 is never written and reads zero.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issue_config.svh"

module int_regfile
    import issue_pkg::*;
#(
    parameter int unsigned NR_WRITE_PORTS = `NR_COMMIT_PORTS
) (
    input  wire logic                                clk_i,
    input  wire logic                                rst_ni,
    // read ports, addressed by rs1 / rs2
    input  wire logic [`REG_ADDR_BITS-1:0]           raddr_a_i,
    input  wire logic [`REG_ADDR_BITS-1:0]           raddr_b_i,
    output logic      [`XLEN-1:0]                    rdata_a_o,
    output logic      [`XLEN-1:0]                    rdata_b_o,
    // write ports from commit
    input  commit_port_t [NR_WRITE_PORTS-1:0]        commit_i
);

    // register storage
    logic [`XLEN-1:0] mem_q [`NR_REGS];

    // ----------------------------------------
    // write side
    // ----------------------------------------
    // ports are walked in ascending order so the highest port wins
    // on an address collision
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 0; r < `NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            for (int unsigned p = 0; p < NR_WRITE_PORTS; p++) begin
                // x0 is hardwired, drop any write to it
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------
    // no write-through, a commit in this cycle shows up next cycle
    // x0 forced to zero on the read path as well
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule

`default_nettype wire

// File: hw/issue_pkg.sv
/*
  Shared types of the issue stage: unit and operation enums, the scoreboard
  entry, forwarding answer, commit port, unit ready/valid groups and the
  clobber list. Used by every RTL module of the stage and by the testbench.
*/
`default_nettype none
`include "issue_config.svh"

package issue_pkg;

    // functional unit that executes an entry
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT,
        CSR
    } fu_t;

    // operation inside the unit
    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        XOR_OP,
        SLL,
        BEQ,
        BNE,
        JALR,
        LW,
        SW,
        MUL,
        CSR_RW,
        SFENCE_VMA
    } fu_op_t;

    // ----------------------------------------
    // scoreboard side
    // ----------------------------------------
    // result carries the immediate while the entry waits for issue
    typedef struct packed {
        logic [`XLEN-1:0]          pc;
        logic [`TRANS_ID_BITS-1:0] trans_id;
        fu_t                       fu;
        fu_op_t                    op;
        logic [`REG_ADDR_BITS-1:0] rs1;
        logic [`REG_ADDR_BITS-1:0] rs2;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [`XLEN-1:0]          result;
        logic                      use_imm;
        logic                      use_pc;
        logic                      use_zimm;
        logic                      ex_valid;
    } issue_entry_t;

    // in-flight values returned for rs1_o / rs2_o
    typedef struct packed {
        logic [`XLEN-1:0] rs1_data;
        logic             rs1_valid;
        logic [`XLEN-1:0] rs2_data;
        logic             rs2_valid;
    } fwd_t;

    // one register file write from commit
    typedef struct packed {
        logic                      we;
        logic [`REG_ADDR_BITS-1:0] waddr;
        logic [`XLEN-1:0]          wdata;
    } commit_port_t;

    // pending writer unit per integer register, NONE when free
    typedef fu_t [`NR_REGS-1:0] clobber_t;

    // ----------------------------------------
    // execute side
    // ----------------------------------------
    // flu is the fixed-latency unit (alu, branch, mult, csr)
    typedef struct packed {
        logic flu;
        logic lsu;
    } unit_ready_t;

    typedef struct packed {
        fu_t                       fu;
        fu_op_t                    op;
        logic [`XLEN-1:0]          operand_a;
        logic [`XLEN-1:0]          operand_b;
        logic [`XLEN-1:0]          imm;
        logic [`TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

endpackage

`default_nettype wire

// File: hw/issue_config.svh
/*
  Width and port-count constants for the integer issue and operand-read stage.
  Include this in any file that sizes registers, tags or commit ports.
*/
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// integer data path width
`define XLEN 32
// architectural register address and count
`define REG_ADDR_BITS 5
`define NR_REGS 32
// scoreboard tag width
`define TRANS_ID_BITS 3
// write ports coming from the commit stage
`define NR_COMMIT_PORTS 2

`endif
